//--- Makefile
VERILATOR ?= verilator
TOP       ?= wbuf_tb
FILELIST  ?= wbuf_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/wbuf_axi_slave.sv
`timescale 1ns/1ps

module wbuf_axi_slave
    import wbuf_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  axi_aw_t aw_i,
    input  logic    aw_valid_i,
    output logic    aw_ready_o,
    input  axi_w_t  w_i,
    input  logic    w_valid_i,
    output logic    w_ready_o,
    output logic    b_valid_o,
    input  logic    b_ready_i
);

    axi_aw_t     aw_q[$];  // handshakes popped by the testbench
    axi_w_t      w_q[$];
    logic [31:0] lfsr;
    int          aw_seen;
    int          last_seen;
    int          b_seen;
    int          b_taken;  // responses already dropped
    int          b_wait;   // -1 while no delay is drawn
    int          r;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    task automatic draw_bits(input int n, output int val);
        int i;
        val = 0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            val = val * 2 + int'(lfsr[0]);
        end
    endtask

    initial begin
        aw_seen = 0;
        last_seen = 0;
        b_seen = 0;
        forever begin
            @(posedge clock);
            if (!reset) begin
                if (aw_valid_i && aw_ready_o) begin
                    aw_q.push_back(aw_i);
                    aw_seen++;
                end
                if (w_valid_i && w_ready_o) begin
                    w_q.push_back(w_i);
                    if (w_i.last) last_seen++;
                end
                if (b_valid_o && b_ready_i) b_seen++;
            end
        end
    end

    initial begin
        lfsr = 32'ha5aa_70d5;
        aw_ready_o = 1'b0;
        w_ready_o = 1'b0;
        b_valid_o = 1'b0;
        b_taken = 0;
        b_wait = -1;
        forever begin
            @(negedge clock);
            if (reset) begin
                aw_ready_o = 1'b0;
                w_ready_o = 1'b0;
                b_valid_o = 1'b0;
            end else begin
                draw_bits(2, r);
                aw_ready_o = (r == 0);  // slow address so data often wins
                draw_bits(1, r);
                w_ready_o = (r != 0);
                if (b_valid_o) begin
                    if (b_seen != b_taken) begin
                        b_valid_o = 1'b0;
                        b_taken = b_seen;
                    end
                end else if (aw_seen > b_taken && last_seen > b_taken) begin
                    if (b_wait < 0) draw_bits(2, b_wait);  // 0 to 3 cycles
                    if (b_wait == 0) begin
                        b_valid_o = 1'b1;
                        b_wait = -1;
                    end else begin
                        b_wait--;
                    end
                end
            end
        end
    end

endmodule

//--- sim/wbuf_tb.sv
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module wbuf_tb
    import wbuf_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int NUM_REQS   = 24;

    logic      clock;
    logic      reset;
    logic      req_valid;
    wbuf_req_t req;
    logic      req_ready;
    axi_aw_t   aw;
    logic      aw_valid;
    logic      aw_ready;
    axi_w_t    w;
    logic      w_valid;
    logic      w_ready;
    logic      b_valid;
    logic      b_ready;

    wbuf_req_t model_q[$];  // accepted requests awaiting their check
    int        errors;
    int        timeouts;
    int        accepted;
    int        aw_total;
    int        b_total;
    logic      aw_open;    // AW seen and B still to come
    wtype_t    wtype;
    int        n;

    wbuf_top dut (
        .clock(clock), .reset(reset),
        .req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
        .aw_o(aw), .aw_valid_o(aw_valid), .aw_ready_i(aw_ready),
        .w_o(w), .w_valid_o(w_valid), .w_ready_i(w_ready),
        .b_valid_i(b_valid), .b_ready_o(b_ready)
    );

    wbuf_axi_slave slave (
        .clock(clock), .reset(reset),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_valid_o(b_valid), .b_ready_i(b_ready)
    );

    initial begin
        clock = 1'b0;
        forever #20 clock = ~clock;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("[ERROR] %0t ns: %s", $time, msg);
    endtask

    function automatic logic [2:0] expected_size(input wtype_t t);
        case (t)
            `WTYPE_BYTE: return `AXI_SIZE_1;
            `WTYPE_HALF: return `AXI_SIZE_2;
            default:     return `AXI_SIZE_4;
        endcase
    endfunction

    // word k of request n carries both indices
    function automatic wbuf_req_t make_request(input int n, input wtype_t t);
        wbuf_req_t r;
        int        k;
        r.wtype = t;
        r.addr = 32'h2000_0000 | 32'(n << 5);
        for (k = 0; k < `WBUF_BEATS; k++) begin
            r.data[k*32 +: 32] = {8'(n), 8'(k), 8'(n) ^ 8'ha5, 8'(k) + 8'h3c};
        end
        r.strb = 4'b1111;
        if (t == `WTYPE_BYTE) begin
            r.addr[1:0] = 2'(n >> 2);
            r.strb = 4'b0001 << r.addr[1:0];
        end else if (t == `WTYPE_HALF) begin
            r.addr[1:0] = {n[2], 1'b0};
            r.strb = 4'b0011 << r.addr[1:0];
        end else if (t == `WTYPE_LINE) begin
            r.strb = 4'b0000;  // don't care for a line
        end
        return r;
    endfunction

    // held until the payload is taken
    assert property (@(posedge clock) disable iff (reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw))
        else report_error("AW valid or payload changed before ready");
    assert property (@(posedge clock) disable iff (reset)
        w_valid && !w_ready |=> w_valid && $stable(w))
        else report_error("W valid or payload changed before ready");
    assert property (@(posedge clock) disable iff (reset)
        req_valid && req_ready |=> aw_valid && w_valid && !req_ready)
        else report_error("AW and W valid not raised one cycle after acceptance");
    assert property (@(posedge clock) disable iff (reset)
        !req_ready && !(b_valid && b_ready) |=> !req_ready)
        else report_error("req_ready rose before the B handshake");
    assert property (@(posedge clock) disable iff (reset)
        b_valid && b_ready |=> req_ready)
        else report_error("req_ready low after the B handshake");

    always @(posedge clock) begin
        if (!reset) begin
            if (aw_valid && aw_ready) begin
                assert (!aw_open) else report_error("second AW before the B handshake");
                aw_open = 1'b1;
                aw_total++;
            end
            if (b_valid && b_ready) begin
                assert (aw_open) else report_error("B handshake without an AW");
                aw_open = 1'b0;
                b_total++;
            end
            if (req_valid && req_ready) accepted++;
        end
    end

    task automatic send_request(input wbuf_req_t r);
        int cycles;
        cycles = 0;
        req = r;
        req_valid = 1'b1;
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("request was never accepted, gave up after %0d cycles", cycles);
        end else begin
            @(posedge clock);
            model_q.push_back(r);
        end
        @(negedge clock);
        req_valid = 1'b0;
        req = wbuf_req_t'(~r);  // latch must not follow the bus
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (!req_ready && cycles < WAIT_LIMIT) begin
            @(negedge clock);
            cycles++;
        end
        if (!req_ready) begin
            timeouts++;
            $display("write did not complete, gave up after %0d cycles", cycles);
        end
    endtask

    task automatic check_done();
        wbuf_req_t exp;
        axi_aw_t   got_aw;
        axi_w_t    got_w;
        int        beats;
        int        k;
        if (model_q.size() > 0) begin
            exp = model_q.pop_front();
            beats = (exp.wtype == `WTYPE_LINE) ? `WBUF_BEATS : 1;
            assert (slave.aw_q.size() == 1)
                else report_error($sformatf("%0d AW handshakes, exp 1", slave.aw_q.size()));
            if (slave.aw_q.size() > 0) begin
                got_aw = slave.aw_q.pop_front();
                assert (got_aw.addr == exp.addr)
                    else report_error($sformatf("AW addr %h exp %h", got_aw.addr, exp.addr));
                assert (got_aw.len == 8'(beats - 1))
                    else report_error($sformatf("AW len %0d exp %0d", got_aw.len, beats - 1));
                assert (got_aw.size == expected_size(exp.wtype))
                    else report_error($sformatf("AW size %0d wrong", got_aw.size));
            end
            assert (slave.w_q.size() == beats)
                else report_error($sformatf("%0d W beats, exp %0d", slave.w_q.size(), beats));
            for (k = 0; k < beats && slave.w_q.size() > 0; k++) begin
                got_w = slave.w_q.pop_front();
                assert (got_w.data == exp.data[k*32 +: 32])
                    else report_error($sformatf("beat %0d data %h", k, got_w.data));
                assert (got_w.strb == ((beats > 1) ? 4'b1111 : exp.strb))
                    else report_error($sformatf("beat %0d strobe %b", k, got_w.strb));
                assert (got_w.last == (k == beats - 1))
                    else report_error($sformatf("beat %0d last %b", k, got_w.last));
            end
        end
        slave.aw_q.delete();
        slave.w_q.delete();
    endtask

    initial begin
        errors = 0;
        timeouts = 0;
        accepted = 0;
        aw_total = 0;
        b_total = 0;
        aw_open = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        assert (!aw_valid && !w_valid && !b_ready && req_ready)
            else report_error("ports not idle after reset");
        for (n = 0; n < NUM_REQS; n++) begin
            case (n % 4)
                0:       wtype = `WTYPE_BYTE;
                1:       wtype = `WTYPE_HALF;
                2:       wtype = `WTYPE_WORD;
                default: wtype = `WTYPE_LINE;
            endcase
            send_request(make_request(n, wtype));
            wait_idle();
            check_done();
        end
        assert (accepted == aw_total && accepted == b_total)
            else report_error($sformatf("%0d accepted, %0d AW, %0d B",
                                        accepted, aw_total, b_total));
        $display("%0d requests, %0d errors, %0d timeouts", accepted, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- verilog/wbuf_beat_counter.sv
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module wbuf_beat_counter
    import wbuf_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      accept_i,
    input  logic      beat_fire_i,
    input  logic      is_line_i,
    output beat_idx_t beat_idx_o,
    output logic      last_beat_o,
    output logic      burst_done_o
);

    beat_idx_t beat_idx_q;
    logic      done_q;

    // final index is 7 for a line, 0 for a single write
    assign last_beat_o = is_line_i ? (beat_idx_q == beat_idx_t'(`WBUF_BEATS - 1))
                                   : (beat_idx_q == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            beat_idx_q <= '0;
            done_q     <= 1'b0;
        end else if (accept_i) begin
            beat_idx_q <= '0; // fresh start for every request
            done_q     <= 1'b0;
        end else if (beat_fire_i) begin
            if (last_beat_o) begin
                done_q <= 1'b1; // index parks on the last beat
            end else begin
                beat_idx_q <= beat_idx_q + 1'b1;
            end
        end
    end

    assign beat_idx_o   = beat_idx_q;
    assign burst_done_o = done_q;

endmodule

//--- verilog/wbuf_ctrl_fsm.sv
`timescale 1ns/1ps

module wbuf_ctrl_fsm
    import wbuf_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  logic        req_valid_i,
    input  logic        aw_ready_i,
    input  logic        burst_done_i,
    input  logic        b_valid_i,
    output logic        accept_o,
    output wbuf_state_e state_o,
    output logic        aw_valid_o,
    output logic        w_pending_o,
    output logic        b_ready_o,
    output logic        req_ready_o
);

    wbuf_state_e state_q;
    wbuf_state_e state_d;
    logic        aw_done_q;  // address handshake seen for this request
    logic        aw_fire;

    assign req_ready_o = (state_q == IDLE);
    assign accept_o    = req_valid_i & req_ready_o;

    // address and data run independently inside SEND
    assign aw_valid_o  = (state_q == SEND) & ~aw_done_q;
    assign w_pending_o = (state_q == SEND) & ~burst_done_i;
    assign b_ready_o   = (state_q == RESP);

    assign aw_fire = aw_valid_o & aw_ready_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            aw_done_q <= 1'b0;
        end else if (accept_o) begin
            aw_done_q <= 1'b0;
        end else if (aw_fire) begin
            aw_done_q <= 1'b1;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = SEND;
                end
            end
            SEND: begin
                // a handshake in this very cycle counts as done
                if ((aw_done_q | aw_fire) & burst_done_i) begin
                    state_d = RESP;
                end
            end
            RESP: begin
                if (b_valid_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

endmodule

//--- verilog/wbuf_line_store.sv
`timescale 1ns/1ps
`include "wbuf_macros.svh"

module wbuf_line_store
    import wbuf_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      accept_i,
    input  wbuf_req_t req_i,
    input  beat_idx_t beat_idx_i,
    input  logic      last_beat_i,
    output axi_aw_t   aw_o,
    output axi_w_t    w_o,
    output logic      is_line_o
);

    wbuf_req_t  req_q;     // latched request
    logic       is_line_q;
    logic [2:0] size;
    word_t      beat_word;

    // request payload, loaded on accept
    always_ff @(posedge clock) begin
        if (accept_i) begin
            req_q <= req_i;
        end
    end

    // selects burst or single beat
    always_ff @(posedge clock) begin
        if (reset) begin
            is_line_q <= 1'b0;
        end else if (accept_i) begin
            is_line_q <= (req_i.wtype == `WTYPE_LINE);
        end
    end

    always_comb begin
        case (req_q.wtype)
            `WTYPE_BYTE: size = `AXI_SIZE_1;
            `WTYPE_HALF: size = `AXI_SIZE_2;
            `WTYPE_WORD: size = `AXI_SIZE_4;
            default:     size = `AXI_SIZE_4; // line beats are full words
        endcase
    end

    // word k of the line goes out on beat k
    // single writes stay at index 0, so they get word 0
    assign beat_word = req_q.data[{beat_idx_i, 5'b0} +: $bits(word_t)];

    always_comb begin
        aw_o.addr = req_q.addr;
        aw_o.len  = is_line_q ? 8'(`WBUF_BEATS - 1) : 8'd0;
        aw_o.size = size;
    end

    always_comb begin
        w_o.data = beat_word;
        w_o.strb = is_line_q ? strb_t'('1) : req_q.strb;
        w_o.last = last_beat_i;
    end

    assign is_line_o = is_line_q;

endmodule

//--- verilog/wbuf_macros.svh
`ifndef WBUF_MACROS_SVH
`define WBUF_MACROS_SVH

// 32-byte cache lines of 32-bit words
`define WBUF_LINE_OFF_W   5
`define WBUF_BEATS        8
`define WBUF_BEAT_IDX_W   3

// awsize encodings by bytes per beat
`define AXI_SIZE_1        3'b000
`define AXI_SIZE_2        3'b001
`define AXI_SIZE_4        3'b010

// write type codes from the cache
`define WTYPE_BYTE        3'b000
`define WTYPE_HALF        3'b001
`define WTYPE_WORD        3'b010
`define WTYPE_LINE        3'b100 // whole line write-back

`endif

//--- verilog/wbuf_pkg.sv
`include "wbuf_macros.svh"

package wbuf_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [(1 << `WBUF_LINE_OFF_W) * 8 - 1:0] line_t;
    typedef logic [2:0]  wtype_t;
    typedef logic [`WBUF_BEAT_IDX_W-1:0] beat_idx_t;

    // request as handed over by the cache
    typedef struct packed {
        addr_t  addr;
        line_t  data;  // word 0 in the low bits
        strb_t  strb;  // single writes only
        wtype_t wtype;
    } wbuf_req_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;  // beats minus one
        logic [2:0] size;
    } axi_aw_t;

    typedef struct packed {
        word_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef enum logic [1:0] {
        IDLE,
        SEND,  // address and data phases overlap here
        RESP
    } wbuf_state_e;

endpackage

//--- verilog/wbuf_top.sv
`timescale 1ns/1ps

module wbuf_top
    import wbuf_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    // cache side
    input  logic      req_valid_i,
    input  wbuf_req_t req_i,
    output logic      req_ready_o,
    // write address
    output axi_aw_t   aw_o,
    output logic      aw_valid_o,
    input  logic      aw_ready_i,
    // write data
    output axi_w_t    w_o,
    output logic      w_valid_o,
    input  logic      w_ready_i,
    // write response
    input  logic      b_valid_i,
    output logic      b_ready_o
);

    logic      accept;
    logic      w_pending;
    logic      beat_fire;
    logic      burst_done;
    logic      last_beat;
    logic      is_line;
    beat_idx_t beat_idx;

    assign beat_fire = w_pending & w_ready_i;
    assign w_valid_o = w_pending;

    wbuf_ctrl_fsm u_ctrl (
        .clock        (clock),
        .reset        (reset),
        .req_valid_i  (req_valid_i),
        .aw_ready_i   (aw_ready_i),
        .burst_done_i (burst_done),
        .b_valid_i    (b_valid_i),
        .accept_o     (accept),
        .state_o      (),           // state not needed at the ports
        .aw_valid_o   (aw_valid_o),
        .w_pending_o  (w_pending),
        .b_ready_o    (b_ready_o),
        .req_ready_o  (req_ready_o)
    );

    wbuf_beat_counter u_beats (
        .clock        (clock),
        .reset        (reset),
        .accept_i     (accept),
        .beat_fire_i  (beat_fire),
        .is_line_i    (is_line),
        .beat_idx_o   (beat_idx),
        .last_beat_o  (last_beat),
        .burst_done_o (burst_done)
    );

    wbuf_line_store u_store (
        .clock        (clock),
        .reset        (reset),
        .accept_i     (accept),
        .req_i        (req_i),
        .beat_idx_i   (beat_idx),
        .last_beat_i  (last_beat),
        .aw_o         (aw_o),
        .w_o          (w_o),
        .is_line_o    (is_line)
    );

endmodule

//--- wbuf_top.f
+incdir+verilog
verilog/wbuf_pkg.sv
verilog/wbuf_beat_counter.sv
verilog/wbuf_line_store.sv
verilog/wbuf_ctrl_fsm.sv
verilog/wbuf_top.sv
sim/wbuf_axi_slave.sv
sim/wbuf_tb.sv
